/* common/spi_peek_config.svh */
// Build-time sizes for the SPI peek/poke register path.
// Include in any file that needs address widths, word widths,
// bank sizes or the unmapped-device read value.

`ifndef SPI_PEEK_CONFIG_SVH
`define SPI_PEEK_CONFIG_SVH

// Full address carried by an SPI frame
`define SPI_ADDR_BITS 32

// Upper address half selects the device
`define HSS_DEV_SEL_BITS (`SPI_ADDR_BITS - 16)

// Register word width
`define VAL_BITS 32

// Registers per B2B and peripheral bank
`define HSS_DEV_REGS 4

// Ring network bank is larger
`define RING_DEV_REGS 8

// Returned when no device matches the select field
`define SPI_BAD_READ_VALUE 32'hDEAD_BEEF

`endif

/* common/spi_frame_pkg.sv */
// Definitions of the 72-bit SPI frame.
// A frame is a command byte, an address and a data word, MSB first.
// Imported by the SPI slave and by the frame checks in the testbench.

`include "spi_peek_config.svh"

package spi_frame_pkg;

  // Command byte values, anything else is ignored
  typedef enum logic [7:0] {
    SPI_CMD_READ  = 8'h01,
    SPI_CMD_WRITE = 8'h02
  } spi_cmd_e;

  // Where in the frame the next bit lands
  typedef enum logic [1:0] {
    SPI_PHASE_CMD,
    SPI_PHASE_ADDR,
    SPI_PHASE_DATA
  } spi_phase_e;

  localparam int SPI_CMD_BITS = 8;

  // Command, address and data together
  localparam int SPI_FRAME_BITS = SPI_CMD_BITS + `SPI_ADDR_BITS + `VAL_BITS;

endpackage

/* common/hss_regs_pkg.sv */
// Definitions of the HSS register space behind the SPI path.
// Device codes match the upper address half of a frame.
// Imported by the decoder, the register banks and the top level.

`include "spi_peek_config.svh"

package hss_regs_pkg;

  // Device select codes
  typedef enum logic [`HSS_DEV_SEL_BITS-1:0] {
    HSS_DEV_B2B0   = 16'h0000,
    HSS_DEV_B2B1   = 16'h0001,
    HSS_DEV_PERIPH = 16'h0002,
    HSS_DEV_RING   = 16'h0003
  } hss_dev_e;

  // One register word
  typedef logic [`VAL_BITS-1:0] reg_word_t;

  // Word offset inside a device, address bits 15:2
  typedef logic [13:0] reg_offset_t;

endpackage

/* spi_slave/spi_slave_shift.sv */
// Mode 0 SPI slave for register peek and poke.
// Brings sclk, cs_n and mosi into the clk domain, collects the
// command, address and data of each frame and pulses one read or
// write strobe per valid frame. Read data goes back on miso, MSB
// first, one bit per falling sclk edge.

`timescale 1ns/100ps
`include "spi_peek_config.svh"

module spi_slave_shift
  import spi_frame_pkg::*;
  import hss_regs_pkg::*;
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sclk,
  input  logic                      cs_n,
  input  logic                      mosi,
  output logic                      miso,
  output logic [`SPI_ADDR_BITS-1:0] spi_addr,
  output reg_word_t                 spi_wdata,
  output logic                      spi_read,
  output logic                      spi_write,
  input  reg_word_t                 spi_read_value
);

  localparam int CNT_BITS = $clog2(SPI_FRAME_BITS + 1);
  localparam logic [CNT_BITS-1:0] LAST_CMD_BIT = CNT_BITS'(SPI_CMD_BITS - 1);
  localparam logic [CNT_BITS-1:0] LAST_ADDR_BIT = CNT_BITS'(SPI_CMD_BITS + `SPI_ADDR_BITS - 1);
  localparam logic [CNT_BITS-1:0] LAST_DATA_BIT = CNT_BITS'(SPI_FRAME_BITS - 1);
  localparam logic [CNT_BITS-1:0] FRAME_END = CNT_BITS'(SPI_FRAME_BITS);

  // Two-stage synchronizers, bit 1 is the usable output
  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_prev;

  logic                    sclk_rise;
  logic                    sclk_fall;
  logic                    cs_active;
  logic                    shift_en;
  logic [CNT_BITS-1:0]     bit_cnt;
  spi_phase_e              phase;
  logic [SPI_CMD_BITS-1:0] cmd_shift;
  spi_cmd_e                cmd_code;
  reg_word_t               tx_shift;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;
  assign cs_active = ~cs_sync[1];

  // Bits past the end of a full frame are dropped
  assign shift_en = cs_active && sclk_rise && (bit_cnt != FRAME_END);

  assign cmd_code = spi_cmd_e'(cmd_shift);

  // Bit counter, phase and strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt   <= '0;
      phase     <= SPI_PHASE_CMD;
      cmd_shift <= '0;
      spi_read  <= 1'b0;
      spi_write <= 1'b0;
    end else begin
      spi_read  <= 1'b0;
      spi_write <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
        phase   <= SPI_PHASE_CMD;
      end else if (shift_en) begin
        bit_cnt <= bit_cnt + 1'b1;
        case (phase)
          SPI_PHASE_CMD: begin
            cmd_shift <= {cmd_shift[SPI_CMD_BITS-2:0], mosi_sync[1]};
            if (bit_cnt == LAST_CMD_BIT) begin
              phase <= SPI_PHASE_ADDR;
            end
          end
          SPI_PHASE_ADDR: begin
            if (bit_cnt == LAST_ADDR_BIT) begin
              phase    <= SPI_PHASE_DATA;
              spi_read <= (cmd_code == SPI_CMD_READ);
            end
          end
          SPI_PHASE_DATA: begin
            if (bit_cnt == LAST_DATA_BIT) begin
              spi_write <= (cmd_code == SPI_CMD_WRITE);
            end
          end
          default: phase <= SPI_PHASE_CMD;
        endcase
      end
    end
  end

  // Address and data shift in place and hold through the strobe
  always_ff @(posedge clk) begin
    if (shift_en && phase == SPI_PHASE_ADDR) begin
      spi_addr <= {spi_addr[`SPI_ADDR_BITS-2:0], mosi_sync[1]};
    end
    if (shift_en && phase == SPI_PHASE_DATA) begin
      spi_wdata <= {spi_wdata[`VAL_BITS-2:0], mosi_sync[1]};
    end
  end

  // Read return, loaded at the end of the read strobe cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift <= '0;
      miso     <= 1'b0;
    end else if (!cs_active) begin
      tx_shift <= '0;
      miso     <= 1'b0;
    end else if (spi_read) begin
      tx_shift <= spi_read_value;
    end else if (sclk_fall) begin
      miso     <= tx_shift[`VAL_BITS-1];
      tx_shift <= {tx_shift[`VAL_BITS-2:0], 1'b0};
    end
  end

endmodule

/* logic/spi_address_decode.sv */
// Splits SPI accesses across the four HSS register banks.
// The upper address half picks the device, bits 15:2 give the word
// offset. Purely combinational, strobes pass through in the same cycle.

`timescale 1ns/100ps
`include "spi_peek_config.svh"

module spi_address_decode
  import hss_regs_pkg::*;
(
  input  logic [`SPI_ADDR_BITS-1:0] spi_addr,
  input  logic                      spi_read,
  input  logic                      spi_write,
  output reg_word_t                 spi_read_value,
  output reg_offset_t               addr,
  output logic [1:0]                b2b_read,
  output logic                      periph_read,
  output logic                      ring_read,
  output logic [1:0]                b2b_write,
  output logic                      periph_write,
  output logic                      ring_write,
  input  reg_word_t [1:0]           b2b_read_value,
  input  reg_word_t                 periph_read_value,
  input  reg_word_t                 ring_read_value
);

  logic [`HSS_DEV_SEL_BITS-1:0] dev;
  logic [1:0]                   b2b_sel;
  logic                         periph_sel;
  logic                         ring_sel;

  assign dev  = spi_addr[`SPI_ADDR_BITS-1:16];
  assign addr = spi_addr[15:2];

  assign b2b_sel[0] = (dev == HSS_DEV_B2B0);
  assign b2b_sel[1] = (dev == HSS_DEV_B2B1);
  assign periph_sel = (dev == HSS_DEV_PERIPH);
  assign ring_sel   = (dev == HSS_DEV_RING);

  assign b2b_read    = b2b_sel & {2{spi_read}};
  assign periph_read = periph_sel & spi_read;
  assign ring_read   = ring_sel & spi_read;

  assign b2b_write    = b2b_sel & {2{spi_write}};
  assign periph_write = periph_sel & spi_write;
  assign ring_write   = ring_sel & spi_write;

  // Unmapped devices read back a fixed marker word
  always_comb begin
    case (dev)
      HSS_DEV_B2B0:   spi_read_value = b2b_read_value[0];
      HSS_DEV_B2B1:   spi_read_value = b2b_read_value[1];
      HSS_DEV_PERIPH: spi_read_value = periph_read_value;
      HSS_DEV_RING:   spi_read_value = ring_read_value;
      default:        spi_read_value = `SPI_BAD_READ_VALUE;
    endcase
  end

endmodule

/* logic/hss_reg_bank.sv */
// Register bank of one HSS device.
// Holds NUM_REGS writable words addressed by word offset. Register 0
// doubles as the device's control word. Reads are combinational and
// return zero outside a read strobe or for offsets beyond the bank.

`timescale 1ns/100ps

module hss_reg_bank
  import hss_regs_pkg::*;
#(
  parameter int NUM_REGS = 4
) (
  input  logic        clk,
  input  logic        arst_n,
  input  reg_offset_t addr,
  input  logic        read,
  input  logic        write,
  input  reg_word_t   wdata,
  output reg_word_t   read_value,
  output reg_word_t   ctrl
);

  localparam int IDX_BITS = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

  reg_word_t           regs [NUM_REGS];
  logic                in_range;
  logic [IDX_BITS-1:0] idx;

  assign in_range = (addr < reg_offset_t'(NUM_REGS));
  assign idx      = addr[IDX_BITS-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write && in_range) begin
      regs[idx] <= wdata;
    end
  end

  // Idle-low read bus
  assign read_value = (read && in_range) ? regs[idx] : '0;

  assign ctrl = regs[0];

endmodule

/* logic/spi_peek_poke_top.sv */
// SPI peek/poke access to the HSS register banks.
// An SPI slave feeds the address decoder, which strobes one of four
// banks. Register 0 of each bank is brought out as a control word.

`timescale 1ns/100ps
`include "spi_peek_config.svh"

module spi_peek_poke_top
  import hss_regs_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      sclk,
  input  logic      cs_n,
  input  logic      mosi,
  output logic      miso,
  output reg_word_t b2b0_ctrl,
  output reg_word_t b2b1_ctrl,
  output reg_word_t periph_ctrl,
  output reg_word_t ring_ctrl
);

  logic [`SPI_ADDR_BITS-1:0] spi_addr;
  reg_word_t                 spi_wdata;
  logic                      spi_read;
  logic                      spi_write;
  reg_word_t                 spi_read_value;

  reg_offset_t     addr;
  logic [1:0]      b2b_read;
  logic [1:0]      b2b_write;
  logic            periph_read;
  logic            periph_write;
  logic            ring_read;
  logic            ring_write;
  reg_word_t [1:0] b2b_read_value;
  reg_word_t       periph_read_value;
  reg_word_t       ring_read_value;

  spi_slave_shift i_spi_slave_shift (
    .clk            (clk),
    .arst_n         (arst_n),
    .sclk           (sclk),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .spi_addr       (spi_addr),
    .spi_wdata      (spi_wdata),
    .spi_read       (spi_read),
    .spi_write      (spi_write),
    .spi_read_value (spi_read_value)
  );

  spi_address_decode i_spi_address_decode (
    .spi_addr          (spi_addr),
    .spi_read          (spi_read),
    .spi_write         (spi_write),
    .spi_read_value    (spi_read_value),
    .addr              (addr),
    .b2b_read          (b2b_read),
    .periph_read       (periph_read),
    .ring_read         (ring_read),
    .b2b_write         (b2b_write),
    .periph_write      (periph_write),
    .ring_write        (ring_write),
    .b2b_read_value    (b2b_read_value),
    .periph_read_value (periph_read_value),
    .ring_read_value   (ring_read_value)
  );

  hss_reg_bank #(.NUM_REGS(`HSS_DEV_REGS)) i_b2b0_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .addr       (addr),
    .read       (b2b_read[0]),
    .write      (b2b_write[0]),
    .wdata      (spi_wdata),
    .read_value (b2b_read_value[0]),
    .ctrl       (b2b0_ctrl)
  );

  hss_reg_bank #(.NUM_REGS(`HSS_DEV_REGS)) i_b2b1_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .addr       (addr),
    .read       (b2b_read[1]),
    .write      (b2b_write[1]),
    .wdata      (spi_wdata),
    .read_value (b2b_read_value[1]),
    .ctrl       (b2b1_ctrl)
  );

  hss_reg_bank #(.NUM_REGS(`HSS_DEV_REGS)) i_periph_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .addr       (addr),
    .read       (periph_read),
    .write      (periph_write),
    .wdata      (spi_wdata),
    .read_value (periph_read_value),
    .ctrl       (periph_ctrl)
  );

  hss_reg_bank #(.NUM_REGS(`RING_DEV_REGS)) i_ring_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .addr       (addr),
    .read       (ring_read),
    .write      (ring_write),
    .wdata      (spi_wdata),
    .read_value (ring_read_value),
    .ctrl       (ring_ctrl)
  );

endmodule

/* dv/spi_peek_properties.sv */
// Concurrent checks on the read and write strobes of the SPI slave.
// Bound into every spi_slave_shift instance. Keeps a count of failed
// assertions for the end of the run.

`timescale 1ns/100ps

module spi_peek_properties (
  input logic clk,
  input logic arst_n,
  input logic cs_n,
  input logic spi_read,
  input logic spi_write
);

  int excl_fails;
  int width_fails;
  int cs_fails;
  int fail_count;

  assign fail_count = excl_fails + width_fails + cs_fails;

  // Read and write never fire together
  strobe_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(spi_read && spi_write))
    else begin
      $error("read and write strobes high in the same cycle");
      excl_fails++;
    end

  // Every strobe is a single-cycle pulse
  strobe_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    (spi_read || spi_write) |=> !(spi_read || spi_write))
    else begin
      $error("strobe held high for more than one cycle");
      width_fails++;
    end

  strobe_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
    (spi_read || spi_write) |-> !cs_n)
    else begin
      $error("strobe issued while cs_n is high");
      cs_fails++;
    end

endmodule

bind spi_slave_shift spi_peek_properties i_spi_peek_properties (
  .clk       (clk),
  .arst_n    (arst_n),
  .cs_n      (cs_n),
  .spi_read  (spi_read),
  .spi_write (spi_write)
);

/* dv/spi_peek_checker.sv */
// Watches the SPI pins and control outputs of the peek/poke DUT.
// Decodes each frame from mosi and miso, keeps a model of all four
// register banks, compares read data and control words, and prints
// one line per test plus a closing line with the counts.

`timescale 1ns/100ps
`include "spi_peek_config.svh"

module spi_peek_checker
  import hss_regs_pkg::*;
(
  input  logic      sclk,
  input  logic      cs_n,
  input  logic      mosi,
  input  logic      miso,
  input  reg_word_t b2b0_ctrl,
  input  reg_word_t b2b1_ctrl,
  input  reg_word_t periph_ctrl,
  input  reg_word_t ring_ctrl,
  input  logic      test_done,
  input  int        test_num,
  input  logic      all_done,
  output int        error_count
);

  // Banks by device, ring bank is the widest
  reg_word_t   model [4][8] = '{default: '0};
  logic [71:0] rx_frame;
  reg_word_t   rx_miso;
  int          nbits;
  logic        frame_open;
  int          checks;
  int          errors_before;
  int          test_errs;
  int          tests_run;
  int          tests_failed;

  function automatic int bank_size(input int dev);
    return (dev == 3) ? `RING_DEV_REGS : `HSS_DEV_REGS;
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1: return "reset values";
      2: return "random write and read back";
      3: return "unmapped devices";
      4: return "offsets beyond bank size";
      5: return "invalid and aborted frames";
      6: return "random mix";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_word(input string name, input reg_word_t expected,
                            input reg_word_t actual);
    checks++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
    end
  endtask

  task automatic apply_frame();
    logic [7:0] cmd;
    int         dev;
    int         off;
    reg_word_t  expected;
    cmd = rx_frame[71:64];
    dev = int'(rx_frame[63:48]);
    off = int'(rx_frame[47:34]);
    if (cmd == 8'h02) begin
      if (dev < 4 && off < bank_size(dev)) begin
        model[2'(dev)][3'(off)] = rx_frame[31:0];
      end
    end else if (cmd == 8'h01) begin
      if (dev >= 4) begin
        expected = `SPI_BAD_READ_VALUE;
      end else if (off >= bank_size(dev)) begin
        expected = '0;
      end else begin
        expected = model[2'(dev)][3'(off)];
      end
      check_word("miso read data", expected, rx_miso);
    end
  endtask

  task automatic compare_ctrl();
    check_word("b2b0_ctrl", model[0][0], b2b0_ctrl);
    check_word("b2b1_ctrl", model[1][0], b2b1_ctrl);
    check_word("periph_ctrl", model[2][0], periph_ctrl);
    check_word("ring_ctrl", model[3][0], ring_ctrl);
  endtask

  // Mode 0, both lines sampled on the rising sclk edge
  always begin
    @(negedge cs_n);
    nbits = 0;
    frame_open = 1'b1;
    while (frame_open) begin
      @(posedge sclk or posedge cs_n);
      if (cs_n) begin
        frame_open = 1'b0;
      end else if (nbits < 72) begin
        rx_frame = {rx_frame[70:0], mosi};
        // Read data returns during the data phase
        if (nbits >= 40) begin
          rx_miso = {rx_miso[30:0], miso};
        end
        nbits++;
      end
    end
    if (nbits == 72) begin
      apply_frame();
    end
    compare_ctrl();
  end

  always @(posedge test_done) begin
    test_errs = error_count - errors_before;
    errors_before = error_count;
    tests_run++;
    if (test_errs != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d errors", test_num, test_name(test_num), test_errs);
  end

  always @(posedge all_done) begin
    $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, error_count);
  end

endmodule

/* dv/spi_peek_tb.sv */
// Testbench for the SPI peek/poke register path.
// Drives random SPI mode 0 frames into the DUT. Checking is done by
// spi_peek_checker, strobe timing by the bound properties.

`timescale 1ns/100ps
`include "spi_peek_config.svh"

module spi_peek_tb
  import hss_regs_pkg::*;
();

  // Frames per test: 4, 24+20, 12+20, 16+20, 13+20, 300
  localparam int FRAMES = 4 + 44 + 32 + 36 + 33 + 300;
  localparam longint WATCHDOG_NS = longint'(FRAMES) * 76 * 1600 + 100_000;

  logic      clk;
  logic      arst_n;
  logic      sclk;
  logic      cs_n;
  logic      mosi;
  logic      miso;
  reg_word_t b2b0_ctrl;
  reg_word_t b2b1_ctrl;
  reg_word_t periph_ctrl;
  reg_word_t ring_ctrl;
  logic      test_done;
  logic      all_done;
  int        test_num;
  int        error_count;

  spi_peek_poke_top i_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .b2b0_ctrl   (b2b0_ctrl),
    .b2b1_ctrl   (b2b1_ctrl),
    .periph_ctrl (periph_ctrl),
    .ring_ctrl   (ring_ctrl)
  );

  spi_peek_checker i_checker (
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .b2b0_ctrl   (b2b0_ctrl),
    .b2b1_ctrl   (b2b1_ctrl),
    .periph_ctrl (periph_ctrl),
    .ring_ctrl   (ring_ctrl),
    .test_done   (test_done),
    .test_num    (test_num),
    .all_done    (all_done),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  function automatic int bank_regs(input int dev);
    return (dev == 3) ? `RING_DEV_REGS : `HSS_DEV_REGS;
  endfunction

  function automatic logic [31:0] make_addr(input int dev, input int off);
    return {16'(dev), 14'(off), 2'b00};
  endfunction

  // 8 clk per sclk half period, cs_n drops early to cut a frame short
  task automatic send_frame(input logic [7:0] cmd, input logic [31:0] addr,
                            input logic [31:0] data, input int nbits);
    logic [71:0] frame;
    frame = {cmd, addr, data};
    cs_n = 1'b0;
    mosi = frame[71];
    wait_clks(8);
    for (int i = 0; i < nbits; i++) begin
      sclk = 1'b1;
      wait_clks(8);
      sclk = 1'b0;
      if (i < 71) begin
        mosi = frame[70 - i];
      end
      wait_clks(8);
    end
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_clks(8);
  endtask

  task automatic write_reg(input int dev, input int off, input reg_word_t data);
    send_frame(8'h02, make_addr(dev, off), data, 72);
  endtask

  task automatic read_reg(input int dev, input int off);
    send_frame(8'h01, make_addr(dev, off), $urandom, 72);
  endtask

  task automatic read_all_mapped();
    for (int dev = 0; dev < 4; dev++) begin
      for (int off = 0; off < bank_regs(dev); off++) begin
        read_reg(dev, off);
      end
    end
  endtask

  task automatic end_test(input int n);
    test_num = n;
    test_done = 1'b1;
    wait_clks(1);
    test_done = 1'b0;
    wait_clks(1);
  endtask

  initial begin
    int         dev;
    int         off;
    int         sel;
    int         prop_fails;
    logic [7:0] cmd;
    arst_n = 1'b0;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    test_done = 1'b0;
    all_done = 1'b0;
    test_num = 0;
    void'($urandom(47));
    repeat (16) @(posedge clk);
    #10;
    arst_n = 1'b1;
    wait_clks(4);

    for (dev = 0; dev < 4; dev++) begin
      read_reg(dev, 0);
    end
    end_test(1);

    for (int n = 0; n < 24; n++) begin
      dev = $urandom % 4;
      write_reg(dev, $urandom % bank_regs(dev), $urandom);
    end
    read_all_mapped();
    end_test(2);

    for (int n = 0; n < 12; n++) begin
      dev = 4 + $urandom % 65532;
      if (n < 6) begin
        write_reg(dev, $urandom % 4, $urandom);
      end else begin
        read_reg(dev, $urandom % 4);
      end
    end
    read_all_mapped();
    end_test(3);

    for (dev = 0; dev < 4; dev++) begin
      off = bank_regs(dev) + $urandom % 64;
      write_reg(dev, off, $urandom);
      read_reg(dev, off);
    end
    // Offsets 4 to 7 exist only in the ring bank
    for (dev = 0; dev < 4; dev++) begin
      off = 4 + $urandom % 4;
      write_reg(dev, off, $urandom);
      read_reg(dev, off);
    end
    read_all_mapped();
    end_test(4);

    for (int n = 0; n < 6; n++) begin
      cmd = 8'($urandom);
      if (cmd == 8'h01 || cmd == 8'h02) begin
        cmd = 8'hA5;
      end
      dev = $urandom % 4;
      send_frame(cmd, make_addr(dev, $urandom % bank_regs(dev)), $urandom, 72);
    end
    for (int n = 0; n < 6; n++) begin
      dev = $urandom % 4;
      send_frame(8'h02, make_addr(dev, $urandom % bank_regs(dev)), $urandom,
                 1 + $urandom % 71);
    end
    send_frame(8'h01, make_addr(3, 5), $urandom, 56);
    read_all_mapped();
    end_test(5);

    for (int n = 0; n < 300; n++) begin
      sel = $urandom % 5;
      dev = (sel < 4) ? sel : 4 + $urandom % 200;
      off = $urandom % 10;
      if ($urandom % 2 == 0) begin
        write_reg(dev, off, $urandom);
      end else begin
        read_reg(dev, off);
      end
    end
    end_test(6);

    all_done = 1'b1;
    wait_clks(1);
    prop_fails = i_dut.i_spi_slave_shift.i_spi_peek_properties.fail_count;
    if (prop_fails != 0) begin
      $display("%0d strobe assertions failed during the run", prop_fails);
    end
    if (error_count == 0 && prop_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/spi_frame_pkg.sv
common/hss_regs_pkg.sv
spi_slave/spi_slave_shift.sv
logic/spi_address_decode.sv
logic/hss_reg_bank.sv
logic/spi_peek_poke_top.sv
dv/spi_peek_properties.sv
dv/spi_peek_checker.sv
dv/spi_peek_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the SPI peek/poke testbench with Verilator and run it.
# Exits non-zero unless the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module spi_peek_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vspi_peek_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
